/* Makefile */
# Verilator build for the stream gateway.

VERILATOR ?= verilator
FILELIST  := files.f
TOP       := gateway_tb
RTL_TOP   := gateway_top
BUILD_DIR := obj_dir
FLAGS     := --timing --assert

.PHONY: all lint sim clean

all: sim

# lint the design on its own, then together with the testbench.
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the run gives a failing exit status.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
verilog/gw_geometry_pkg.sv
verilog/gw_types_pkg.sv
verilog/lane_capture.sv
verilog/line_reader.sv
verilog/gateway_top.sv
verif/gateway_checker.sv
verif/gateway_tb.sv

/* verif/gateway_checker.sv */
module gateway_checker #(
	parameter int N_LINES        = gw_geometry_pkg::N_LINES,
	parameter int LANES_PER_LINE = gw_geometry_pkg::LANES_PER_LINE
) (
	input  logic                                                   aclk,
	input  logic                                                   arst_n,
	input  logic [N_LINES*LANES_PER_LINE*gw_geometry_pkg::LANE_W-1:0] lane_tdata,
	input  logic [N_LINES*LANES_PER_LINE-1:0]                      lane_tvalid,
	input  logic [N_LINES*LANES_PER_LINE-1:0]                      lane_tready,
	input  gw_types_pkg::line_t                                    m_tdata,
	input  logic                                                   m_tvalid,
	input  logic                                                   m_tready,
	output logic                                                   failed
);

	localparam int N_LANES = N_LINES * LANES_PER_LINE;
	localparam int W       = gw_geometry_pkg::LANE_W;

	// a lane holds one word downstream and one in its slot at most.
	gw_types_pkg::lane_t front [N_LANES];
	gw_types_pkg::lane_t back [N_LANES];
	int unsigned depth [N_LANES];

	int unsigned exp_idx; // next line expected on the output.
	logic any_accepted;
	logic stall_q;
	gw_types_pkg::line_t tdata_q;
	logic [N_LANES-1:0] accepted_q;
	logic [N_LANES-1:0] ready_q;

	always @(posedge aclk or negedge arst_n) begin
		gw_types_pkg::line_t expect_line;
		logic complete;
		int unsigned base;
		if (!arst_n) begin
			for (int i = 0; i < N_LANES; i++) begin
				depth[i] = 0;
			end
			exp_idx = 0;
			any_accepted = 1'b0;
			stall_q = 1'b0;
			accepted_q = '0;
			ready_q = '1;
			failed <= 1'b0;
		end else begin

			// ****************************************
			// reset state and back-pressure
			// ****************************************

			if (!any_accepted) begin
				assert (!m_tvalid) else begin
					$display("mismatch m_tvalid before first accept: expected 0, got %h",
						m_tvalid);
					failed <= 1'b1;
				end
				assert (&lane_tready) else begin
					$display("mismatch lane_tready before first accept: expected %h, got %h",
						{N_LANES{1'b1}}, lane_tready);
					failed <= 1'b1;
				end
			end

			if (stall_q) begin // stalled on the last edge.
				assert (m_tvalid) else begin
					$display("mismatch m_tvalid under back-pressure: expected 1, got %h",
						m_tvalid);
					failed <= 1'b1;
				end
				assert (m_tdata == tdata_q) else begin
					$display("mismatch m_tdata under back-pressure: expected %h, got %h",
						tdata_q, m_tdata);
					failed <= 1'b1;
				end
			end

			// ****************************************
			// lane ready
			// ****************************************

			for (int i = 0; i < N_LANES; i++) begin
				if (accepted_q[i]) begin
					assert (!lane_tready[i]) else begin
						$display("mismatch lane_tready[%0d] after accept: expected 0, got %h",
							i, lane_tready[i]);
						failed <= 1'b1;
					end
				end
				// a release only comes with a load into the output register.
				if (lane_tready[i] && !ready_q[i]) begin
					assert (m_tvalid) else begin
						$display("lane %0d became ready again while no line was loaded", i);
						failed <= 1'b1;
					end
				end
			end

			// ****************************************
			// line model
			// ****************************************

			if (m_tvalid && m_tready) begin
				complete = 1'b1;
				base = exp_idx * LANES_PER_LINE;
				expect_line = '0;
				for (int j = 0; j < LANES_PER_LINE; j++) begin
					if (depth[base+j] == 0) begin
						complete = 1'b0;
					end
					expect_line[j] = front[base+j];
				end
				assert (complete) else begin
					$display("line %0d was sent before all of its lanes were accepted", exp_idx);
					failed <= 1'b1;
				end
				if (complete) begin
					assert (m_tdata == expect_line) else begin
						$display("mismatch m_tdata for line %0d: expected %h, got %h",
							exp_idx, expect_line, m_tdata);
						failed <= 1'b1;
					end
				end
				for (int j = 0; j < LANES_PER_LINE; j++) begin
					front[base+j] = back[base+j];
					if (depth[base+j] > 0) begin
						depth[base+j] = depth[base+j] - 1;
					end
				end
				exp_idx = (exp_idx + 1) % N_LINES;
			end

			for (int i = 0; i < N_LANES; i++) begin
				if (lane_tvalid[i] && lane_tready[i]) begin
					any_accepted = 1'b1;
					assert (depth[i] < 2) else begin
						$display("lane %0d accepted a word twice in one round", i);
						failed <= 1'b1;
					end
					if (depth[i] == 0) begin
						front[i] = lane_tdata[i*W +: W];
						depth[i] = 1;
					end else if (depth[i] == 1) begin
						back[i] = lane_tdata[i*W +: W];
						depth[i] = 2;
					end
				end
			end

			stall_q = m_tvalid && !m_tready;
			tdata_q = m_tdata;
			accepted_q = lane_tvalid & lane_tready;
			ready_q = lane_tready;
		end
	end

endmodule : gateway_checker

/* verif/gateway_tb.sv */
module gateway_tb;

	localparam int N_LINES        = gw_geometry_pkg::N_LINES;
	localparam int LANES_PER_LINE = gw_geometry_pkg::LANES_PER_LINE;
	localparam int N_LANES        = N_LINES * LANES_PER_LINE;
	localparam int W              = gw_geometry_pkg::LANE_W;

	localparam int ROUNDS     = 6; // the first one is the directed round.
	localparam int EARLY_LINE = 2; // filled ahead of line 0.
	localparam int TIMEOUT    = ROUNDS * N_LINES * LANES_PER_LINE * 20 + 1000;

	logic                   aclk;
	logic                   arst_n;
	logic [N_LANES*W-1:0]   lane_tdata;
	logic [N_LANES-1:0]     lane_tvalid;
	logic [N_LANES-1:0]     lane_tready;
	gw_types_pkg::line_t    m_tdata;
	logic                   m_tvalid;
	logic                   m_tready;
	logic                   check_failed;

	int unsigned accepted [N_LANES]; // words taken per lane.
	int unsigned target;
	logic [N_LANES-1:0] allow;
	int unsigned stall_pct;
	int unsigned lines_out;

	gateway_top dut (
		.aclk        (aclk),
		.arst_n      (arst_n),
		.lane_tdata  (lane_tdata),
		.lane_tvalid (lane_tvalid),
		.lane_tready (lane_tready),
		.m_tdata     (m_tdata),
		.m_tvalid    (m_tvalid),
		.m_tready    (m_tready)
	);

	gateway_checker #(
		.N_LINES        (N_LINES),
		.LANES_PER_LINE (LANES_PER_LINE)
	) u_checker (
		.aclk        (aclk),
		.arst_n      (arst_n),
		.lane_tdata  (lane_tdata),
		.lane_tvalid (lane_tvalid),
		.lane_tready (lane_tready),
		.m_tdata     (m_tdata),
		.m_tvalid    (m_tvalid),
		.m_tready    (m_tready),
		.failed      (check_failed)
	);

	// ****************************************
	// helpers
	// ****************************************

	function automatic gw_types_pkg::lane_t random_word();
		random_word = gw_types_pkg::lane_t'({$urandom, $urandom});
	endfunction

	function automatic logic line_done(int k, int unsigned n);
		line_done = 1'b1;
		for (int j = 0; j < LANES_PER_LINE; j++) begin
			if (accepted[k*LANES_PER_LINE+j] < n) begin
				line_done = 1'b0;
			end
		end
	endfunction

	function automatic logic all_sent();
		all_sent = 1'b1;
		for (int i = 0; i < N_LANES; i++) begin
			if (accepted[i] < target) begin
				all_sent = 1'b0;
			end
		end
	endfunction

	// one clock of lane sources and sink.
	task automatic drive_cycle();
		@(posedge aclk);
		if (m_tvalid && m_tready) begin
			lines_out++;
		end
		for (int i = 0; i < N_LANES; i++) begin
			if (lane_tvalid[i] && lane_tready[i]) begin
				accepted[i]++;
				lane_tvalid[i] <= 1'b0;
			end else if (!lane_tvalid[i] && allow[i] && accepted[i] < target &&
					$urandom_range(99) < 60) begin
				lane_tvalid[i] <= 1'b1;
				lane_tdata[i*W +: W] <= random_word();
			end
		end
		m_tready <= ($urandom_range(99) >= stall_pct);
	endtask

	task automatic run_until(int unsigned n_lines);
		while (!(all_sent() && lines_out >= n_lines)) begin
			drive_cycle();
		end
	endtask

	// ****************************************
	// clock, watchdog, error stop
	// ****************************************

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	initial begin
		#(TIMEOUT);
		$display("the run took too long, %0d of %0d lines came out", lines_out,
			ROUNDS * N_LINES);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	always @(negedge aclk) begin
		if (check_failed) begin
			$display("Something failed");
			$fatal(1, "checker reported an error");
		end
	end

	// ****************************************
	// stimulus
	// ****************************************

	initial begin
		void'($urandom(74));
		arst_n = 1'b0;
		lane_tdata = '0;
		lane_tvalid = '0;
		m_tready = 1'b0;
		allow = '0;
		target = 0;
		stall_pct = 100;
		lines_out = 0;
		for (int i = 0; i < N_LANES; i++) begin
			accepted[i] = 0;
		end
		repeat (2) @(posedge aclk);
		arst_n <= 1'b1;
		repeat (3) drive_cycle(); // idle after reset.

		// early line completes while the sink is stalled.
		target = 1;
		allow[EARLY_LINE*LANES_PER_LINE +: LANES_PER_LINE] = '1;
		while (!line_done(EARLY_LINE, 1)) begin
			drive_cycle();
		end
		repeat (8) drive_cycle();

		// sink opens while line 0 is still empty.
		stall_pct = 0;
		repeat (8) drive_cycle();
		allow[0 +: LANES_PER_LINE] = '1;
		while (!line_done(0, 1)) begin
			drive_cycle();
		end
		allow = '1;
		run_until(N_LINES);

		// random rounds under back-pressure.
		target = ROUNDS;
		stall_pct = 30;
		run_until(ROUNDS * N_LINES);
		repeat (5) drive_cycle();

		@(negedge aclk);
		#1;
		if (check_failed) begin
			$display("Something failed");
			$fatal(1, "checker reported an error");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule : gateway_tb

/* verilog/gateway_top.sv */
module gateway_top #(
	parameter int N_LINES        = gw_geometry_pkg::N_LINES,
	parameter int LANES_PER_LINE = gw_geometry_pkg::LANES_PER_LINE
) (
	input  logic                                                   aclk,
	input  logic                                                   arst_n,

	// lane side with lane i at slice i.
	input  logic [N_LINES*LANES_PER_LINE*gw_geometry_pkg::LANE_W-1:0] lane_tdata,
	input  logic [N_LINES*LANES_PER_LINE-1:0]                      lane_tvalid,
	output logic [N_LINES*LANES_PER_LINE-1:0]                      lane_tready,

	// line stream out.
	output gw_types_pkg::line_t                                    m_tdata,
	output logic                                                   m_tvalid,
	input  logic                                                   m_tready
);

	// lane bits feeding one line.
	localparam int LINE_BITS = LANES_PER_LINE * gw_geometry_pkg::LANE_W;

	gw_types_pkg::line_t line_data [N_LINES];
	logic [N_LINES-1:0] line_full;
	logic [N_LINES-1:0] line_release;

	// ****************************************
	// line slots
	// ****************************************

	generate
		for (genvar g = 0; g < N_LINES; g++) begin : g_line
			lane_capture #(
				.LANES_PER_LINE (LANES_PER_LINE)
			) u_capture (
				.aclk         (aclk),
				.arst_n       (arst_n),
				.tdata        (lane_tdata[g*LINE_BITS +: LINE_BITS]),
				.tvalid       (lane_tvalid[g*LANES_PER_LINE +: LANES_PER_LINE]),
				.line_release (line_release[g]),
				.tready       (lane_tready[g*LANES_PER_LINE +: LANES_PER_LINE]),
				.line_data    (line_data[g]),
				.line_full    (line_full[g])
			);
		end
	endgenerate

	// ****************************************
	// in-order readout
	// ****************************************

	line_reader #(
		.N_LINES (N_LINES)
	) u_reader (
		.aclk         (aclk),
		.arst_n       (arst_n),
		.line_data    (line_data),
		.line_full    (line_full),
		.m_tready     (m_tready),
		.line_release (line_release),
		.m_tdata      (m_tdata),
		.m_tvalid     (m_tvalid)
	);

endmodule : gateway_top

/* verilog/gw_geometry_pkg.sv */
package gw_geometry_pkg;

	// one lane word.
	localparam int LANE_W = 64;

	// lanes gathered into one output line.
	localparam int LANES_PER_LINE = 8;

	// lines held in the gateway.
	localparam int N_LINES = 8;

endpackage : gw_geometry_pkg

/* verilog/gw_types_pkg.sv */
package gw_types_pkg;

	// smallest index width that holds every line.
	localparam int IDX_W = (gw_geometry_pkg::N_LINES > 1) ?
		$clog2(gw_geometry_pkg::N_LINES) : 1;

	// one word as carried by a single lane.
	typedef logic [gw_geometry_pkg::LANE_W-1:0] lane_t;

	// a full output line; element 0 is lane 0 and sits in the low bits.
	typedef lane_t [gw_geometry_pkg::LANES_PER_LINE-1:0] line_t;

	// position in the cyclic line order.
	typedef logic [IDX_W-1:0] line_idx_t;

endpackage : gw_types_pkg

/* verilog/lane_capture.sv */
module lane_capture #(
	parameter int LANES_PER_LINE = gw_geometry_pkg::LANES_PER_LINE
) (
	input  logic                                             aclk,
	input  logic                                             arst_n,
	input  logic [LANES_PER_LINE*gw_geometry_pkg::LANE_W-1:0] tdata,
	input  logic [LANES_PER_LINE-1:0]                        tvalid,
	input  logic                                             line_release,
	output logic [LANES_PER_LINE-1:0]                        tready,
	output gw_types_pkg::line_t                              line_data,
	output logic                                             line_full
);

	localparam int W = gw_geometry_pkg::LANE_W;

	gw_types_pkg::lane_t slot [LANES_PER_LINE];
	logic [LANES_PER_LINE-1:0] filled;
	logic [LANES_PER_LINE-1:0] accept;

	// ****************************************
	// per-slot capture
	// ****************************************

	generate
		for (genvar i = 0; i < LANES_PER_LINE; i++) begin : g_slot

			// handshake only while the slot is empty.
			assign accept[i] = tvalid[i] & ~filled[i];
			assign tready[i] = ~filled[i];

			always_ff @(posedge aclk or negedge arst_n) begin
				if (!arst_n) begin
					filled[i] <= 1'b0;
				end else if (line_release) begin
					filled[i] <= 1'b0; // release has priority.
				end else if (accept[i]) begin
					filled[i] <= 1'b1;
				end
			end

			// word storage.
			always_ff @(posedge aclk) begin
				if (accept[i]) begin
					slot[i] <= tdata[i*W +: W];
				end
			end

		end
	endgenerate

	// ****************************************
	// line view
	// ****************************************

	// complete once every slot holds a word.
	assign line_full = &filled;

	always_comb begin
		line_data = '0; // unused upper lanes stay zero.
		for (int i = 0; i < LANES_PER_LINE; i++) begin
			line_data[i] = slot[i];
		end
	end

endmodule : lane_capture

/* verilog/line_reader.sv */
module line_reader #(
	parameter int N_LINES = gw_geometry_pkg::N_LINES
) (
	input  logic                aclk,
	input  logic                arst_n,
	input  gw_types_pkg::line_t line_data [N_LINES],
	input  logic [N_LINES-1:0]  line_full,
	input  logic                m_tready,
	output logic [N_LINES-1:0]  line_release,
	output gw_types_pkg::line_t m_tdata,
	output logic                m_tvalid
);

	gw_types_pkg::line_idx_t rd_idx;
	gw_types_pkg::line_idx_t rd_idx_next;
	gw_types_pkg::line_t head_data;
	logic head_full;
	logic out_free;
	logic load;

	// ****************************************
	// head of the line order
	// ****************************************

	// only the line whose turn it is gets looked at.
	assign head_full = line_full[rd_idx];
	assign head_data = line_data[rd_idx];

	// register empty, or emptied on this edge.
	assign out_free = !m_tvalid || m_tready;

	assign load = head_full && out_free;

	// wrap at the line count.
	always_comb begin
		if (rd_idx == gw_types_pkg::line_idx_t'(N_LINES - 1)) begin
			rd_idx_next = '0;
		end else begin
			rd_idx_next = rd_idx + gw_types_pkg::line_idx_t'(1);
		end
	end

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			rd_idx <= '0;
		end else if (load) begin
			rd_idx <= rd_idx_next;
		end
	end

	// ****************************************
	// output register
	// ****************************************

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			m_tvalid <= 1'b0;
		end else if (load) begin
			m_tvalid <= 1'b1;
		end else if (m_tready) begin
			m_tvalid <= 1'b0; // taken with nothing new behind it.
		end
	end

	// held while the sink stalls.
	always_ff @(posedge aclk) begin
		if (load) begin
			m_tdata <= head_data;
		end
	end

	// ****************************************
	// line release
	// ****************************************

	// Pulsed in the load cycle, so the slots empty on the same edge that
	// copies the line out. The lanes can then refill while the copy is
	// still waiting downstream.
	always_comb begin
		line_release = '0;
		if (load) begin
			line_release[rd_idx] = 1'b1;
		end
	end

endmodule : line_reader
